// File: Makefile
TOP := query_buffer_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Regression failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Regression passed" sim.log || (echo "simulation ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: bench/query_buffer_assertions.sv
// protocol checks bound into the buffer top; they look at the loader's wr struct inside the top
`default_nettype none
`timescale 1ns/1ps

`include "query_macros.svh"

module query_buffer_assertions import query_pkg::*; (
  input wire                         clk,
  input wire                         rst,
  input wire                         frame_clear,
  input patch_out_t                  patch_out,
  input wire [`QUERY_ADDR_WIDTH:0]   patch_count,
  input patch_write_t                wr
);

  // valid cycles in a row before this one
  logic [2:0]  valid_run;
  // address the next write strobe must carry
  patch_addr_t next_wr_addr;

  always_ff @(posedge clk) begin
    if (rst || !patch_out.valid) begin
      valid_run <= '0;
    end else if (valid_run != 3'd7) begin
      valid_run <= valid_run + 1'b1;
    end
  end

  // clear restarts the write counter at 0
  always_ff @(posedge clk) begin
    if (rst || frame_clear) begin
      next_wr_addr <= '0;
    end else if (wr.en) begin
      next_wr_addr <= wr.addr + 1'b1;
    end
  end

  // one batch is five beats
  valid_run_limit: assert property (@(posedge clk) disable iff (rst)
    patch_out.valid |-> valid_run < 3'd5)
    else $error("patch_out.valid stayed high for more than five cycles");

  patch_known: assert property (@(posedge clk) disable iff (rst)
    patch_out.valid |-> !$isunknown(patch_out.patch))
    else $error("patch_out.patch has unknown bits while valid");

  count_monotonic: assert property (@(posedge clk) disable iff (rst)
    (patch_count < $past(patch_count)) |-> $past(frame_clear))
    else $error("patch_count went down without a frame clear");

  write_addr_step: assert property (@(posedge clk) disable iff (rst)
    wr.en |-> wr.addr == next_wr_addr)
    else $error("write address did not step by one");

endmodule

bind query_buffer_top query_buffer_assertions query_buffer_assertions_inst (
  .clk         (clk),
  .rst         (rst),
  .frame_clear (frame_clear),
  .patch_out   (patch_out),
  .patch_count (patch_count),
  .wr          (wr)
);

`default_nettype wire

// File: bench/query_buffer_tb.sv
// testbench for the query buffer top; reads only entries already written, so no X comes back
`default_nettype none
`timescale 1ns/1ps

`include "query_macros.svh"

module query_buffer_tb import query_pkg::*; ();

  // tests take about 4300 cycles, mostly pixel loading
  localparam int TIMEOUT_CYCLES = 6000;

  // one expected output beat and the cycle it falls in
  typedef struct packed {
    patch_addr_t addr;
    int          due;
  } expect_t;

  logic                        clk;
  logic                        rst;
  pixel_beat_t                 pixel_in;
  logic                        frame_clear;
  batch_req_t                  batch;
  patch_out_t                  patch_out;
  logic [`QUERY_ADDR_WIDTH:0]  patch_count;

  // reference store and its write pointer
  patch_t      model [`QUERY_DEPTH];
  patch_addr_t wr_ptr = '0;
  expect_t     exp_q [$];
  int          cycles = 0;

  query_buffer_top query_buffer_top_inst (
    .clk         (clk),
    .rst         (rst),
    .pixel_in    (pixel_in),
    .frame_clear (frame_clear),
    .batch       (batch),
    .patch_out   (patch_out),
    .patch_count (patch_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", cycles);
      $display("Regression failed");
      $fatal(1, "run limit reached");
    end
  end

  // output monitor, sampled mid-cycle
  always @(negedge clk) begin
    expect_t head;
    logic    exp_valid;
    if (!rst) begin
      exp_valid = (exp_q.size() != 0) && (exp_q[0].due == cycles);
      assert (patch_out.valid == exp_valid) else begin
        $display("CHECK FAILED time=%0t signal=patch_out.valid expected=%b actual=%b",
                 $time, exp_valid, patch_out.valid);
        $display("Regression failed");
        $fatal(1, "output strobe mismatch");
      end
      if (exp_valid) begin
        head = exp_q.pop_front();
        assert (patch_out.patch == model[head.addr]) else begin
          $display("CHECK FAILED time=%0t signal=patch_out.patch expected=%h actual=%h",
                   $time, model[head.addr], patch_out.patch);
          $display("Regression failed");
          $fatal(1, "patch data mismatch");
        end
      end
    end
  end

  // all tasks start and end 1 ns after a rising edge
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // lane k takes the k-th pixel of the patch
  task automatic load_patches(input int count);
    patch_t packed_patch;
    for (int n = 0; n < count; n++) begin
      for (int k = 0; k < `QUERY_PATCH_SIZE; k++) begin
        pixel_in.valid  = 1'b1;
        pixel_in.pixel  = pixel_t'($urandom());
        packed_patch[k] = pixel_in.pixel;
        idle(1);
      end
      model[wr_ptr] = packed_patch;
      wr_ptr        = wr_ptr + 1'b1;
    end
    pixel_in = '0;
  endtask

  task automatic clear_frame();
    frame_clear = 1'b1;
    idle(1);
    frame_clear = 1'b0;
    wr_ptr      = '0;
  endtask

  task automatic drive_start(input patch_addr_t base);
    batch.start = 1'b1;
    batch.base  = base;
    idle(1);
    batch = '0;
  endtask

  // start is sampled at the next edge, data follows two edges later
  task automatic start_batch(input patch_addr_t base);
    expect_t item;
    for (int k = 0; k < `QUERY_BATCH_LEN; k++) begin
      item.addr = patch_addr_t'(base + k);
      item.due  = cycles + 3 + k;
      exp_q.push_back(item);
    end
    drive_start(base);
  endtask

  task automatic wait_batch_done();
    while (exp_q.size() != 0) begin
      idle(1);
    end
  endtask

  task automatic check_count(input logic [`QUERY_ADDR_WIDTH:0] expected);
    assert (patch_count == expected) else begin
      $display("CHECK FAILED time=%0t signal=patch_count expected=%0d actual=%0d",
               $time, expected, patch_count);
      $display("Regression failed");
      $fatal(1, "patch count mismatch");
    end
  endtask

  initial begin
    void'($urandom(86880));
    rst         = 1'b1;
    pixel_in    = '0;
    frame_clear = 1'b0;
    batch       = '0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    // quiet after reset
    idle(4);
    check_count(0);
    // packing order and start latency
    load_patches(1);
    idle(2);
    check_count(1);
    load_patches(4);
    idle(2);
    start_batch(0);
    wait_batch_done();
    // batch from base 3, second start lands while busy
    load_patches(15);
    idle(2);
    check_count(20);
    start_batch(3);
    idle(1);
    drive_start(10);
    wait_batch_done();
    idle(4);
    // across the bank split
    load_patches(280);
    idle(2);
    check_count(300);
    start_batch(254);
    wait_batch_done();
    // last five entries written so far
    start_batch(295);
    wait_batch_done();
    // clear rewrites from address 0
    clear_frame();
    check_count(0);
    load_patches(1);
    idle(2);
    check_count(1);
    start_batch(0);
    wait_batch_done();
    load_patches(1);
    idle(2);
    start_batch(0);
    wait_batch_done();
    // wrap past 512 and saturate
    clear_frame();
    load_patches(520);
    idle(2);
    check_count(512);
    start_batch(510);
    wait_batch_done();
    start_batch(3);
    wait_batch_done();
    idle(4);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+source
source/query_pkg.sv
source/sram_1rw1r_32x256.sv
source/query_patch_mem.sv
source/query_patch_loader.sv
source/query_batch_reader.sv
source/query_buffer_top.sv
bench/query_buffer_assertions.sv
bench/query_buffer_tb.sv

// File: source/query_batch_reader.sv
// reads five patches from a base address, wrapping at 512; starts while busy are dropped
`default_nettype none
`timescale 1ns/1ps

`include "query_macros.svh"

module query_batch_reader import query_pkg::*; (
  input  wire         clk,
  input  wire         rst,
  input  batch_req_t  batch,
  output patch_read_t rd,
  input  patch_t      rpatch,
  output patch_out_t  patch_out
);

  localparam int CNT_W = $clog2(`QUERY_BATCH_LEN);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`QUERY_BATCH_LEN - 1);

  logic              busy;
  // next address to request
  patch_addr_t       addr_cnt;
  // reads issued in this batch
  logic [CNT_W-1:0]  beat;
  logic              last;
  logic              accept;
  // registered read request
  logic              rd_en_q;
  patch_addr_t       rd_addr_q;
  // request one cycle back, lines up with macro output
  logic              rd_en_d;

  // last read of the batch frees the reader for a back-to-back start
  assign last   = busy && (beat == LAST);
  assign accept = batch.start && (!busy || last);

  // control
  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      beat    <= '0;
      rd_en_q <= 1'b0;
      rd_en_d <= 1'b0;
    end else begin
      rd_en_q <= busy;
      rd_en_d <= rd_en_q;
      if (busy) begin
        beat <= beat + 1'b1;
      end
      if (last) begin
        busy <= 1'b0;
      end
      if (accept) begin
        busy <= 1'b1;
        beat <= '0;
      end
    end
  end

  // addresses
  // wraps naturally modulo 512
  always_ff @(posedge clk) begin
    if (busy) begin
      rd_addr_q <= addr_cnt;
      addr_cnt  <= addr_cnt + 1'b1;
    end
    if (accept) begin
      addr_cnt <= batch.base;
    end
  end

  always_comb begin
    rd.en            = rd_en_q;
    rd.addr          = rd_addr_q;
    patch_out.valid  = rd_en_d;
    patch_out.patch  = rpatch;
  end

endmodule

`default_nettype wire

// File: source/query_buffer_top.sv
// query patch buffer top; all inputs are single-cycle strobes and outputs must be taken when valid
`default_nettype none
`timescale 1ns/1ps

`include "query_macros.svh"

module query_buffer_top import query_pkg::*; (
  input  wire                         clk,
  input  wire                         rst,
  input  pixel_beat_t                 pixel_in,
  input  wire                         frame_clear,
  input  batch_req_t                  batch,
  output patch_out_t                  patch_out,
  output logic [`QUERY_ADDR_WIDTH:0]  patch_count
);

  // loader side
  patch_write_t wr;
  // reader side
  patch_read_t  rd;
  patch_t       rpatch1;

  // pixel packing and write counter
  query_patch_loader query_patch_loader_inst (
    .clk         (clk),
    .rst         (rst),
    .pixel_in    (pixel_in),
    .frame_clear (frame_clear),
    .wr          (wr),
    .patch_count (patch_count)
  );

  // memory pins are active low
  query_patch_mem query_patch_mem_inst (
    .clk     (clk),
    .csb0    (~wr.en),
    .web0    (~wr.en),
    .addr0   (wr.addr),
    .wpatch0 (wr.patch),
    .csb1    (~rd.en),
    .addr1   (rd.addr),
    .rpatch1 (rpatch1)
  );

  // five-patch batch reads
  query_batch_reader query_batch_reader_inst (
    .clk       (clk),
    .rst       (rst),
    .batch     (batch),
    .rd        (rd),
    .rpatch    (rpatch1),
    .patch_out (patch_out)
  );

endmodule

`default_nettype wire

// File: source/query_macros.svh
// geometry of the query patch buffer; the RTL assumes two macro words cover one patch
`ifndef QUERY_MACROS_SVH
`define QUERY_MACROS_SVH

// bits per pixel
`define QUERY_DATA_WIDTH 11

// pixels packed into one patch
`define QUERY_PATCH_SIZE 5

// patch address, top bit picks the bank
`define QUERY_ADDR_WIDTH 9

// patch entries over both banks
`define QUERY_DEPTH 512

// sram macro word and address
`define QUERY_MACRO_WIDTH 32
`define QUERY_MACRO_ADDR_WIDTH 8

// patches returned per batch read
`define QUERY_BATCH_LEN 5

`endif

// File: source/query_patch_loader.sv
// packs five pixels per patch; no back-pressure, write address wraps and overwrites old patches
`default_nettype none
`timescale 1ns/1ps

`include "query_macros.svh"

module query_patch_loader import query_pkg::*; (
  input  wire                          clk,
  input  wire                          rst,
  input  pixel_beat_t                  pixel_in,
  input  wire                          frame_clear,
  output patch_write_t                 wr,
  output logic [`QUERY_ADDR_WIDTH:0]   patch_count
);

  localparam int LANE_W = $clog2(`QUERY_PATCH_SIZE);
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`QUERY_PATCH_SIZE - 1);
  localparam logic [`QUERY_ADDR_WIDTH:0] COUNT_MAX = (`QUERY_ADDR_WIDTH+1)'(`QUERY_DEPTH);

  // next lane to fill
  logic [LANE_W-1:0] lane;
  // lane used by this cycle's beat, clear restarts at 0
  logic [LANE_W-1:0] lane_cur;
  // patch being assembled, complete while wr_en is high
  patch_t            partial;
  logic              wr_en;
  patch_addr_t       wr_addr;

  assign lane_cur = frame_clear ? '0 : lane;

  // lane, write strobe, counters
  always_ff @(posedge clk) begin
    if (rst) begin
      lane        <= '0;
      wr_en       <= 1'b0;
      wr_addr     <= '0;
      patch_count <= '0;
    end else begin
      wr_en <= 1'b0;
      // pending write lands at this edge
      if (wr_en) begin
        wr_addr <= wr_addr + 1'b1;
        if (patch_count != COUNT_MAX) begin
          patch_count <= patch_count + 1'b1;
        end
      end
      // clear wins over the advance
      if (frame_clear) begin
        wr_addr     <= '0;
        patch_count <= '0;
        lane        <= '0;
      end
      if (pixel_in.valid) begin
        if (lane_cur == LAST_LANE) begin
          lane  <= '0;
          wr_en <= 1'b1;
        end else begin
          lane <= lane_cur + 1'b1;
        end
      end
    end
  end

  // pixel lanes
  // next beat refills lane 0 only after the write edge
  always_ff @(posedge clk) begin
    if (pixel_in.valid) begin
      partial[lane_cur] <= pixel_in.pixel;
    end
  end

  // write request to the memory
  always_comb begin
    wr.en    = wr_en;
    wr.addr  = wr_addr;
    wr.patch = partial;
  end

endmodule

`default_nettype wire

// File: source/query_patch_mem.sv
// 512-patch store on four macros; port 0 write only, its readback is not brought out
`default_nettype none
`timescale 1ns/1ps

`include "query_macros.svh"

module query_patch_mem import query_pkg::*; (
  input  wire         clk,
  // write port, active low
  input  wire         csb0,
  input  wire         web0,
  input  patch_addr_t addr0,
  input  patch_t      wpatch0,
  // read port, active low
  input  wire         csb1,
  input  patch_addr_t addr1,
  output patch_t      rpatch1
);

  localparam int BANKS = 2;
  localparam int BANK_BIT = `QUERY_ADDR_WIDTH - 1;

  // per-bank active-low pins
  logic [BANKS-1:0] csb0_bank;
  logic [BANKS-1:0] web0_bank;
  logic [BANKS-1:0] csb1_bank;

  // write word split into halves
  macro_word_u wword;

  // raw port 1 words per bank
  logic [`QUERY_MACRO_WIDTH-1:0] rd_lower [BANKS];
  logic [`QUERY_MACRO_WIDTH-1:0] rd_upper [BANKS];

  // joined read word
  macro_word_u rword;

  // bank that was read at the last port 1 access
  logic rd_bank_q;

  // zero pad over the patch, then seen as two macro words
  always_comb begin
    wword.fields.pad   = '0;
    wword.fields.patch = wpatch0;
  end

  for (genvar b = 0; b < BANKS; b++) begin : g_bank
    // deselect the bank not addressed
    assign csb0_bank[b] = csb0 | (addr0[BANK_BIT] != 1'(b));
    assign web0_bank[b] = web0 | (addr0[BANK_BIT] != 1'(b));
    assign csb1_bank[b] = csb1 | (addr1[BANK_BIT] != 1'(b));

    // low 32 bits of the patch
    sram_1rw1r_32x256 lower_inst (
      .clk0   (clk),
      .csb0   (csb0_bank[b]),
      .web0   (web0_bank[b]),
      .wmask0 ({(`QUERY_MACRO_WIDTH/8){1'b1}}),
      .addr0  (addr0[`QUERY_MACRO_ADDR_WIDTH-1:0]),
      .din0   (wword.halves.lower),
      .dout0  (),
      .clk1   (clk),
      .csb1   (csb1_bank[b]),
      .addr1  (addr1[`QUERY_MACRO_ADDR_WIDTH-1:0]),
      .dout1  (rd_lower[b])
    );

    // top 23 patch bits plus pad
    sram_1rw1r_32x256 upper_inst (
      .clk0   (clk),
      .csb0   (csb0_bank[b]),
      .web0   (web0_bank[b]),
      .wmask0 ({(`QUERY_MACRO_WIDTH/8){1'b1}}),
      .addr0  (addr0[`QUERY_MACRO_ADDR_WIDTH-1:0]),
      .din0   (wword.halves.upper),
      .dout0  (),
      .clk1   (clk),
      .csb1   (csb1_bank[b]),
      .addr1  (addr1[`QUERY_MACRO_ADDR_WIDTH-1:0]),
      .dout1  (rd_upper[b])
    );
  end

  // bank select follows the macro output register
  // held while idle so the mux keeps matching the held data
  always_ff @(posedge clk) begin
    if (!csb1) begin
      rd_bank_q <= addr1[BANK_BIT];
    end
  end

  // join halves of the chosen bank, drop the pad
  always_comb begin
    rword.halves.lower = rd_lower[rd_bank_q];
    rword.halves.upper = rd_upper[rd_bank_q];
    rpatch1            = rword.fields.patch;
  end

endmodule

`default_nettype wire

// File: source/query_pkg.sv
// shared types; a patch must fit in two macro words with the spare bits above it as pad
`default_nettype none

`include "query_macros.svh"

package query_pkg;

  // one pixel
  typedef logic [`QUERY_DATA_WIDTH-1:0] pixel_t;

  // lane 0 is the first pixel in, lowest bits
  typedef pixel_t [`QUERY_PATCH_SIZE-1:0] patch_t;

  // bit 8 selects the bank
  typedef logic [`QUERY_ADDR_WIDTH-1:0] patch_addr_t;

  // incoming pixel strobe
  typedef struct packed {
    logic   valid;
    pixel_t pixel;
  } pixel_beat_t;

  // loader write request
  typedef struct packed {
    logic        en;
    patch_addr_t addr;
    patch_t      patch;
  } patch_write_t;

  // port 1 read request
  typedef struct packed {
    logic        en;
    patch_addr_t addr;
  } patch_read_t;

  // batch start and base address
  typedef struct packed {
    logic        start;
    patch_addr_t base;
  } batch_req_t;

  // patch output strobe
  typedef struct packed {
    logic   valid;
    patch_t patch;
  } patch_out_t;

  // two macro words, upper one on top
  typedef struct packed {
    logic [`QUERY_MACRO_WIDTH-1:0] upper;
    logic [`QUERY_MACRO_WIDTH-1:0] lower;
  } macro_halves_t;

  // same 64 bits seen as pad over a patch
  typedef struct packed {
    logic [2*`QUERY_MACRO_WIDTH-`QUERY_DATA_WIDTH*`QUERY_PATCH_SIZE-1:0] pad;
    patch_t                                                            patch;
  } macro_fields_t;

  // split on write, join on read
  typedef union packed {
    macro_halves_t halves;
    macro_fields_t fields;
  } macro_word_u;

endpackage

`default_nettype wire

// File: source/sram_1rw1r_32x256.sv
// behavioural 32x256 1rw+1r macro model, not a foundry cell; selects active low, read-first
`default_nettype none
`timescale 1ns/1ps

`include "query_macros.svh"

module sram_1rw1r_32x256 (
  // port 0, read or write
  input  wire                                clk0,
  input  wire                                csb0,
  input  wire                                web0,
  input  wire  [`QUERY_MACRO_WIDTH/8-1:0]    wmask0,
  input  wire  [`QUERY_MACRO_ADDR_WIDTH-1:0] addr0,
  input  wire  [`QUERY_MACRO_WIDTH-1:0]      din0,
  output logic [`QUERY_MACRO_WIDTH-1:0]      dout0,
  // port 1, read only
  input  wire                                clk1,
  input  wire                                csb1,
  input  wire  [`QUERY_MACRO_ADDR_WIDTH-1:0] addr1,
  output logic [`QUERY_MACRO_WIDTH-1:0]      dout1
);

  localparam int WORDS = 1 << `QUERY_MACRO_ADDR_WIDTH;

  // storage array
  logic [`QUERY_MACRO_WIDTH-1:0] mem [WORDS];

  // port 0
  // old word goes out even on a write cycle
  always_ff @(posedge clk0) begin
    if (!csb0) begin
      dout0 <= mem[addr0];
      if (!web0) begin
        // byte lanes under the mask only
        for (int b = 0; b < `QUERY_MACRO_WIDTH / 8; b++) begin
          if (wmask0[b]) begin
            mem[addr0][b*8 +: 8] <= din0[b*8 +: 8];
          end
        end
      end
    end
  end

  // port 1
  // nonblocking write above keeps a same-edge read on the old word
  always_ff @(posedge clk1) begin
    if (!csb1) begin
      dout1 <= mem[addr1];
    end
  end

  // deselected port holds its last output

endmodule

`default_nettype wire
